// ==== hw/mipsPkg.sv ====
package mipsPkg;

    // ****************************************
    // words and segments
    // ****************************************
    typedef logic [31:0] instWord;

    localparam instWord bootVector = 32'hBFC00000;  // kseg1 boot rom

    localparam instWord kseg0Base = 32'h80000000;   // unmapped, cached
    localparam instWord kseg1Base = 32'hA0000000;   // unmapped, uncached
    localparam instWord kseg2Base = 32'hC0000000;   // mapped again from here

    localparam instWord physMask = 32'h1FFFFFFF;    // drops the segment bits

    // ****************************************
    // fetch fault kinds
    // ****************************************
    // bit positions in a fault vector, several can be set at once
    localparam int faultMiss = 0;     // no tlb, every mapped address misses
    localparam int faultIllegal = 1;  // unaligned pc
    localparam int faultInvalid = 2;  // nothing behind the address
    localparam int faultKinds = 3;

endpackage

// ==== hw/fetchPkg.sv ====
package fetchPkg;

    // ****************************************
    // instruction memory map
    // ****************************************
    // physical address of word 0, kseg1 0xBFC00000 lands here
    localparam logic [31:0] memBase = 32'h1FC00000;

    // ****************************************
    // default sizes and timing
    // ****************************************
    localparam int defaultMemWords = 16;    // rom depth in words
    localparam int defaultLineWords = 4;    // words per cache line
    localparam int defaultCacheLines = 2;   // direct mapped sets
    localparam int defaultMemLatency = 3;   // cycles before the first word

endpackage

// ==== hw/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage import mipsPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  instWord dNpc,
    input  logic    dStall,
    input  logic    dmStall,
    input  logic    expFlush,
    input  logic    uncached,
    input  logic    sramValid,
    input  instWord sramData,
    input  logic    cacheStall,
    input  instWord cacheData,
    input  logic    instMiss,
    input  logic    instIllegal,
    input  logic    instInvalid,
    output instWord pcWire,
    output instWord iPcReg,
    output instWord iInstr,
    output logic    iInstMiss,
    output logic    iInstIllegal,
    output logic    iInstInvalid,
    output logic    iNextNotReady
);

    instWord pcReg;
    instWord fetched;
    logic    memReady;
    logic    advance;

    // pick the source that serves the current segment
    assign memReady = uncached ? sramValid : !cacheStall;
    assign advance = !dStall && !dmStall && memReady;
    assign fetched = uncached ? sramData : cacheData;

    assign pcWire = pcReg;
    assign iNextNotReady = !advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcReg <= bootVector;
            iPcReg <= '0;
            iInstr <= '0;
            iInstMiss <= 1'b0;
            iInstIllegal <= 1'b0;
            iInstInvalid <= 1'b0;
        end else begin
            if (advance) begin
                pcReg <= dNpc;  // redirect also happens during a flush
            end

            if (expFlush) begin
                iPcReg <= '0;
                iInstr <= '0;
                iInstMiss <= 1'b0;
                iInstIllegal <= 1'b0;
                iInstInvalid <= 1'b0;
            end else if (advance) begin
                iPcReg <= pcReg;
                iInstr <= fetched;
                iInstMiss <= instMiss;
                iInstIllegal <= instIllegal;
                iInstInvalid <= instInvalid;
            end
        end
    end

endmodule

// ==== hw/segmentTranslate.sv ====
`timescale 1ns/1ps

module segmentTranslate import mipsPkg::*, fetchPkg::*; #(
    parameter int memWords = defaultMemWords
) (
    input  instWord pc,
    output instWord physAddr,
    output logic    uncached,
    output logic    instMiss,
    output logic    instIllegal,
    output logic    instInvalid
);

    logic [faultKinds-1:0] faults;
    logic    mapped;
    logic    belowMem;
    logic    pastMem;
    instWord memOffset;

    // ****************************************
    // segment decode
    // ****************************************
    // kuseg and kseg2/3 would need the tlb
    assign mapped = (pc < kseg0Base) || (pc >= kseg2Base);

    assign physAddr = pc & physMask;
    assign uncached = !mapped && (pc >= kseg1Base);  // kseg1 only

    // ****************************************
    // range and alignment
    // ****************************************
    assign memOffset = physAddr - memBase;
    assign belowMem = physAddr < memBase;
    assign pastMem = (memOffset >> 2) >= instWord'(memWords);

    always_comb begin
        faults = '0;
        faults[faultMiss] = mapped;
        faults[faultIllegal] = pc[1:0] != 2'b00;
        faults[faultInvalid] = !mapped && (belowMem || pastMem);  // miss wins
    end

    assign instMiss = faults[faultMiss];
    assign instIllegal = faults[faultIllegal];
    assign instInvalid = faults[faultInvalid];

endmodule

// ==== hw/instCache.sv ====
`timescale 1ns/1ps

module instCache import mipsPkg::*; #(
    parameter int lineWords = 4,
    parameter int cacheLines = 2,
    parameter int memLatency = 3
) (
    input  logic    clk,
    input  logic    reset,
    input  instWord physAddr,
    input  logic    fault,
    input  logic    uncached,
    input  instWord refillData,
    output instWord refillAddr,
    output logic    cacheStall,
    output instWord cacheData
);

    localparam int offW = $clog2(lineWords);
    localparam int idxW = $clog2(cacheLines);
    localparam int tagW = 32 - 2 - offW - idxW;
    localparam int latW = $clog2(memLatency + 1);

    typedef enum logic [1:0] {
        idle,
        waitLat,
        fillLine
    } cacheState;

    cacheState state;
    logic [latW-1:0] latCnt;
    logic [offW-1:0] wordCnt;
    instWord missAddr;

    logic [tagW-1:0]       tags [cacheLines];
    logic [cacheLines-1:0] lineValid;
    instWord               lines [cacheLines][lineWords];

    logic [tagW-1:0] reqTag;
    logic [idxW-1:0] reqIdx;
    logic [offW-1:0] reqOff;
    logic [tagW-1:0] missTag;
    logic [idxW-1:0] missIdx;
    logic active;
    logic hit;
    logic lastWord;

    assign reqTag = physAddr[31 -: tagW];
    assign reqIdx = physAddr[offW + 2 +: idxW];
    assign reqOff = physAddr[2 +: offW];
    assign missTag = missAddr[31 -: tagW];
    assign missIdx = missAddr[offW + 2 +: idxW];

    assign active = !fault && !uncached;  // kseg1 and faults bypass
    assign hit = lineValid[reqIdx] && (tags[reqIdx] == reqTag);
    assign lastWord = wordCnt == offW'(lineWords - 1);

    assign cacheStall = active && ((state != idle) || !hit);
    assign cacheData = (active && hit) ? lines[reqIdx][reqOff] : '0;
    assign refillAddr = {missAddr[31:offW + 2], wordCnt, 2'b00};

    // ****************************************
    // refill FSM
    // ****************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            lineValid <= '0;
            latCnt <= '0;
            wordCnt <= '0;
        end else begin
            case (state)
                idle: begin
                    if (active && !hit) begin
                        state <= waitLat;
                        latCnt <= latW'(1);
                        lineValid[reqIdx] <= 1'b0;  // line is being replaced
                    end
                end
                waitLat: begin
                    if (latCnt == latW'(memLatency)) begin
                        state <= fillLine;
                        wordCnt <= '0;
                    end else begin
                        latCnt <= latCnt + 1'b1;
                    end
                end
                fillLine: begin
                    if (lastWord) begin
                        state <= idle;
                        lineValid[missIdx] <= 1'b1;
                    end else begin
                        wordCnt <= wordCnt + 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if ((state == idle) && active && !hit) begin
            missAddr <= physAddr;
        end
        if (state == fillLine) begin
            lines[missIdx][wordCnt] <= refillData;  // one word per cycle
            if (lastWord) begin
                tags[missIdx] <= missTag;
            end
        end
    end

endmodule

// ==== hw/instSramPort.sv ====
`timescale 1ns/1ps

module instSramPort import mipsPkg::*; #(
    parameter int memLatency = 3
) (
    input  logic    clk,
    input  logic    reset,
    input  instWord physAddr,
    input  logic    fault,
    input  instWord memData,
    output instWord memAddr,
    output logic    sramValid,
    output instWord sramData
);

    localparam int cntW = $clog2(memLatency + 1);

    instWord         lastAddr;
    logic [cntW-1:0] waitCnt;
    logic            addrChanged;
    logic            waitDone;

    assign addrChanged = physAddr != lastAddr;
    assign waitDone = waitCnt == cntW'(memLatency);

    // ****************************************
    // latency counter
    // ****************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            lastAddr <= '0;
            waitCnt <= '0;
        end else if (!fault && addrChanged) begin
            lastAddr <= physAddr;
            waitCnt <= cntW'(1);  // restart on every new address
        end else if (!waitDone) begin
            waitCnt <= waitCnt + 1'b1;
        end
    end

    // memory only sees addresses that passed translation
    assign memAddr = lastAddr;

    // fault answers at once, nothing to wait for
    assign sramValid = fault || (!addrChanged && waitDone);
    assign sramData = fault ? '0 : memData;

endmodule

// ==== hw/instMemory.sv ====
`timescale 1ns/1ps

module instMemory import mipsPkg::*, fetchPkg::*; #(
    parameter int memWords = defaultMemWords
) (
    input  instWord addrA,
    input  instWord addrB,
    output instWord dataA,
    output instWord dataB
);

    localparam int idxW = $clog2(memWords);

    instWord rom [memWords];

    initial begin
        $readmemh("dv/program.hex", rom);
    end

    // byte address to rom word, zero outside the image
    function automatic instWord readWord(input instWord addr);
        instWord offset;
        offset = addr - memBase;
        if ((offset >> 2) < instWord'(memWords)) begin
            return rom[offset[idxW + 1:2]];
        end
        return '0;
    endfunction

    // ****************************************
    // read ports
    // ****************************************
    always_comb begin
        dataA = readWord(addrA);  // uncached port
    end

    always_comb begin
        dataB = readWord(addrB);  // cache refill
    end

endmodule

// ==== hw/fetchTop.sv ====
`timescale 1ns/1ps

module fetchTop import mipsPkg::*, fetchPkg::*; #(
    parameter int memWords = defaultMemWords,
    parameter int lineWords = defaultLineWords,
    parameter int cacheLines = defaultCacheLines,
    parameter int memLatency = defaultMemLatency
) (
    input  logic    clk,
    input  logic    reset,
    input  instWord dNpc,
    input  logic    dStall,
    input  logic    dmStall,
    input  logic    expFlush,
    output instWord iPcReg,
    output instWord iPcWire,
    output instWord iInstr,
    output logic    iInstMiss,
    output logic    iInstIllegal,
    output logic    iInstInvalid,
    output logic    iNextNotReady
);

    instWord physAddr;
    logic    uncached;
    logic    instMiss;
    logic    instIllegal;
    logic    instInvalid;
    logic    fault;
    instWord memAddrA;
    instWord memDataA;
    instWord refillAddr;
    instWord refillData;
    logic    sramValid;
    instWord sramData;
    logic    cacheStall;
    instWord cacheData;

    assign fault = instMiss || instIllegal || instInvalid;

    fetchStage stage (
        .clk(clk), .reset(reset), .dNpc(dNpc), .dStall(dStall), .dmStall(dmStall),
        .expFlush(expFlush), .uncached(uncached), .sramValid(sramValid),
        .sramData(sramData), .cacheStall(cacheStall), .cacheData(cacheData),
        .instMiss(instMiss), .instIllegal(instIllegal), .instInvalid(instInvalid),
        .pcWire(iPcWire), .iPcReg(iPcReg), .iInstr(iInstr), .iInstMiss(iInstMiss),
        .iInstIllegal(iInstIllegal), .iInstInvalid(iInstInvalid),
        .iNextNotReady(iNextNotReady)
    );

    segmentTranslate #(.memWords(memWords)) translate (
        .pc(iPcWire), .physAddr(physAddr), .uncached(uncached), .instMiss(instMiss),
        .instIllegal(instIllegal), .instInvalid(instInvalid)
    );

    instSramPort #(.memLatency(memLatency)) sramPort (
        .clk(clk), .reset(reset), .physAddr(physAddr), .fault(fault),
        .memData(memDataA), .memAddr(memAddrA), .sramValid(sramValid),
        .sramData(sramData)
    );

    instCache #(
        .lineWords(lineWords),
        .cacheLines(cacheLines),
        .memLatency(memLatency)
    ) cache (
        .clk(clk), .reset(reset), .physAddr(physAddr), .fault(fault),
        .uncached(uncached), .refillData(refillData), .refillAddr(refillAddr),
        .cacheStall(cacheStall), .cacheData(cacheData)
    );

    instMemory #(.memWords(memWords)) memory (
        .addrA(memAddrA), .addrB(refillAddr), .dataA(memDataA), .dataB(refillData)
    );

endmodule

// ==== dv/fetchStage_assertions.sv ====
`timescale 1ns/1ps

module fetchStage_assertions import mipsPkg::*, fetchPkg::*; #(
    parameter int memWords = defaultMemWords,
    parameter int lineWords = defaultLineWords,
    parameter int cacheLines = defaultCacheLines
) (
    input logic    clk,
    input logic    reset,
    input instWord dNpc,
    input logic    dStall,
    input logic    dmStall,
    input logic    expFlush,
    input instWord iPcReg,
    input instWord iPcWire,
    input instWord iInstr,
    input logic    iInstMiss,
    input logic    iInstIllegal,
    input logic    iInstInvalid,
    input logic    iNextNotReady
);

    instWord image [memWords];
    int failures = 0;

    instWord lineOf [cacheLines];  // line number last fetched per set
    logic [cacheLines-1:0] lineKnown;
    instWord curLine;
    int curIdx;
    logic [2:0] curFaults;
    logic cachedPc;
    logic knownHit;

    initial begin
        $readmemh("dv/program.hex", image);
    end

    // {invalid, illegal, miss}
    function automatic logic [2:0] expectFaults(input instWord pc);
        instWord phys;
        logic miss;
        logic outside;
        phys = pc & physMask;
        miss = (pc < kseg0Base) || (pc >= kseg2Base);
        outside = (phys < memBase) || (((phys - memBase) >> 2) >= instWord'(memWords));
        return {!miss && outside, pc[1:0] != 2'b00, miss};
    endfunction

    function automatic instWord expectWord(input instWord pc);
        if (expectFaults(pc) != 3'b000) begin
            return '0;
        end
        return image[((pc & physMask) - memBase) >> 2];
    endfunction

    // ****************************************
    // lines the cache must hold by now
    // ****************************************
    assign curFaults = expectFaults(iPcWire);
    assign curLine = (iPcWire & physMask) / instWord'(lineWords * 4);
    assign curIdx = int'(curLine % instWord'(cacheLines));
    assign cachedPc = (iPcWire >= kseg0Base) && (iPcWire < kseg1Base) && (curFaults == 3'b000);
    assign knownHit = cachedPc && lineKnown[curIdx] && (lineOf[curIdx] == curLine);

    always_ff @(posedge clk) begin
        if (reset) begin
            lineKnown <= '0;
        end else if (!iNextNotReady && cachedPc) begin
            lineKnown[curIdx] <= 1'b1;  // refill done once the pc moves on
            lineOf[curIdx] <= curLine;
        end
    end

    // ****************************************
    // stage properties
    // ****************************************
    resetValues: assert property (@(posedge clk) reset |=> (iPcWire == bootVector)
            && (iPcReg == '0) && (iInstr == '0) && !iInstMiss && !iInstIllegal && !iInstInvalid)
        else begin
            failures++;
            $error("stage state after reset is wrong");
        end

    advanceLoads: assert property (@(posedge clk) disable iff (reset)
            (!iNextNotReady && !expFlush) |=> (iPcWire == $past(dNpc))
            && (iPcReg == $past(iPcWire)) && (iInstr == expectWord($past(iPcWire)))
            && ({iInstInvalid, iInstIllegal, iInstMiss} == expectFaults($past(iPcWire))))
        else begin
            failures++;
            $error("advance loaded a wrong pc, instruction or fault");
        end

    notReadyHolds: assert property (@(posedge clk) disable iff (reset)
            (iNextNotReady && !expFlush) |=> $stable(iPcWire) && $stable(iPcReg)
            && $stable(iInstr) && $stable({iInstMiss, iInstIllegal, iInstInvalid}))
        else begin
            failures++;
            $error("stage changed while not ready");
        end

    stallBlocks: assert property (@(posedge clk) disable iff (reset)
            (dStall || dmStall) |-> iNextNotReady)
        else begin
            failures++;
            $error("ready while a stall input is high");
        end

    flushClears: assert property (@(posedge clk) disable iff (reset)
            expFlush |=> (iPcReg == '0) && (iInstr == '0)
            && !iInstMiss && !iInstIllegal && !iInstInvalid
            && (iPcWire == ($past(iNextNotReady) ? $past(iPcWire) : $past(dNpc))))
        else begin
            failures++;
            $error("flush left a wrong pc or decode register");
        end

    // faults and cache hits never wait for memory
    noMemoryWait: assert property (@(posedge clk) disable iff (reset)
            (!dStall && !dmStall && ((curFaults != 3'b000) || knownHit)) |-> !iNextNotReady)
        else begin
            failures++;
            $error("fetch waited on a fault or a cache hit");
        end

endmodule

bind fetchTop fetchStage_assertions #(
    .memWords(memWords),
    .lineWords(lineWords),
    .cacheLines(cacheLines)
) checks (
    .clk(clk), .reset(reset), .dNpc(dNpc), .dStall(dStall), .dmStall(dmStall),
    .expFlush(expFlush), .iPcReg(iPcReg), .iPcWire(iPcWire), .iInstr(iInstr),
    .iInstMiss(iInstMiss), .iInstIllegal(iInstIllegal), .iInstInvalid(iInstInvalid),
    .iNextNotReady(iNextNotReady)
);

// ==== dv/fetchTb.sv ====
`timescale 1ns/1ps

module fetchTb import mipsPkg::*, fetchPkg::*; ();

    localparam int waitLimit = 60;                // cycles per fetch
    localparam instWord kseg0Rom = 32'h9FC00000;  // same rom through kseg0

    logic    clk = 1'b0;
    logic    reset;
    instWord dNpc;
    logic    dStall;
    logic    dmStall;
    logic    expFlush;
    instWord iPcReg;
    instWord iPcWire;
    instWord iInstr;
    logic    iInstMiss;
    logic    iInstIllegal;
    logic    iInstInvalid;
    logic    iNextNotReady;

    integer seed = 32'h9827;
    int tests = 0;
    int failedTests = 0;
    int timeouts = 0;
    int failMark = 0;
    int timeoutMark = 0;

    fetchTop UUT (
        .clk(clk), .reset(reset), .dNpc(dNpc), .dStall(dStall), .dmStall(dmStall),
        .expFlush(expFlush), .iPcReg(iPcReg), .iPcWire(iPcWire), .iInstr(iInstr),
        .iInstMiss(iInstMiss), .iInstIllegal(iInstIllegal), .iInstInvalid(iInstInvalid),
        .iNextNotReady(iNextNotReady)
    );

    always #50 clk = !clk;

    task automatic drawStalls(input logic enable);
        dStall <= enable && (($random(seed) & 3) == 0);
        dmStall <= enable && (($random(seed) & 7) == 0);
    endtask

    // set the next pc and wait until the current pc is fetched
    task automatic advanceTo(input instWord npc, input logic stalls);
        int waited;
        waited = 0;
        @(posedge clk);
        dNpc <= npc;
        drawStalls(stalls);
        @(negedge clk);
        while (iNextNotReady) begin
            if (waited == waitLimit) begin
                timeouts++;
                $display("timeout: pc %h was not fetched within %0d cycles",
                         iPcWire, waitLimit);
                return;
            end
            waited++;
            @(posedge clk);
            drawStalls(stalls);
            @(negedge clk);
        end
    endtask

    // one cycle of expFlush with or without a stall
    task automatic flushOnce(input instWord npc, input logic stalled);
        @(posedge clk);
        dNpc <= npc;
        expFlush <= 1'b1;
        dStall <= stalled;
        @(posedge clk);
        expFlush <= 1'b0;
        dStall <= 1'b0;
        @(negedge clk);
    endtask

    task automatic endTest(input string name);
        int newFails;
        int newTimeouts;
        @(posedge clk);  // last advance
        @(posedge clk);  // its checks
        @(negedge clk);
        newFails = UUT.checks.failures - failMark;
        newTimeouts = timeouts - timeoutMark;
        failMark = UUT.checks.failures;
        timeoutMark = timeouts;
        tests++;
        if (newFails != 0) begin
            failedTests++;
            $display("** Error at time %0t: %s, %0d assertion failures", $time, name, newFails);
        end else if (newTimeouts != 0) begin
            failedTests++;
            $display("%s failed, %0d fetches timed out", name, newTimeouts);
        end else begin
            $display("%s passed", name);
        end
    endtask

    initial begin
        reset = 1'b1;
        dNpc = bootVector;
        dStall = 1'b0;
        dmStall = 1'b0;
        expFlush = 1'b0;

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        endTest("reset");

        for (int i = 1; i < defaultMemWords; i++) begin
            advanceTo(bootVector + 32'(4 * i), 1'b0);
        end
        endTest("uncached fetch");

        // two lines fit the cache so the second round hits
        for (int round = 0; round < 2; round++) begin
            for (int i = 0; i < defaultLineWords * defaultCacheLines; i++) begin
                advanceTo(kseg0Rom + 32'(4 * i), 1'b0);
            end
        end
        endTest("cached fetch");

        for (int i = 0; i < defaultMemWords; i++) begin
            advanceTo(kseg0Rom + 32'(4 * i), 1'b1);
        end
        for (int i = 0; i < 8; i++) begin
            advanceTo(bootVector + 32'(4 * i), 1'b1);
        end
        endTest("random stalls");

        // word 8 is still cached so the first flush advances
        advanceTo(kseg0Rom + 32'd32, 1'b0);
        flushOnce(kseg0Rom + 32'd36, 1'b0);
        flushOnce(bootVector, 1'b1);
        advanceTo(bootVector, 1'b0);
        endTest("flush");

        advanceTo(32'h00400000, 1'b0);  // kuseg
        advanceTo(bootVector + 32'd2, 1'b0);
        advanceTo(bootVector + 32'(4 * defaultMemWords), 1'b0);
        advanceTo(bootVector + 32'd4, 1'b0);
        endTest("fetch faults");

        $display("%0d tests, %0d failed, %0d assertion failures, %0d timeouts",
                 tests, failedTests, UUT.checks.failures, timeouts);
        if ((failedTests == 0) && (UUT.checks.failures == 0) && (timeouts == 0)) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== fetchSubsys.f ====
hw/mipsPkg.sv
hw/fetchPkg.sv
hw/fetchStage.sv
hw/segmentTranslate.sv
hw/instCache.sv
hw/instSramPort.sv
hw/instMemory.sv
hw/fetchTop.sv
dv/fetchStage_assertions.sv
dv/fetchTb.sv

// ==== dv/program.hex ====
// one 32-bit instruction word per line in hex, word 0 at physical 0x1FC00000
3c08a000
25080010
8d090000
00004025
11200004
25290001
ad090004
1000fffc
00005025
3c0a8000
254a0100
01400008
00005825
24020001
0000000c
1000ffff
